// File: verilog/mem_group_defs.svh
`ifndef MEM_GROUP_DEFS_SVH
`define MEM_GROUP_DEFS_SVH

// Counts and widths shared by the memory group

////////////////////////////////
// Processor count
////////////////////////////////
`define NUM_PROC        7    // Processor memories in the group
`define PSEL_W          3    // Processor select width

////////////////////////////////
// Local word port
////////////////////////////////
`define WORD_W          60   // Full data word
`define HALF_W          30   // High or low half of a word
`define ADDR_W          11   // 2048 words per processor

////////////////////////////////
// Wide DDR port
////////////////////////////////
`define LINE_W          240  // Four words side by side
`define LINE_ADDR_W     9    // Line address, also the bank address
`define WORDS_PER_LINE  4    // One word per bank

`endif

// File: verilog/mem_group_pkg.sv
`include "mem_group_defs.svh"

package mem_group_pkg;

  ////////////////////////////////
  // Data types
  ////////////////////////////////
  typedef logic [`WORD_W-1:0] word_t;      // One stored word
  typedef logic [`HALF_W-1:0] half_t;      // Half of a word from the processor side
  typedef logic [`LINE_W-1:0] line_t;      // Word 0 sits in bits 59:0

  ////////////////////////////////
  // Address and select types
  ////////////////////////////////
  typedef logic [`ADDR_W-1:0] addr_t;           // Local word address
  typedef logic [`LINE_ADDR_W-1:0] line_addr_t; // Line address into each bank

  // Bank index, taken from the low word address bits
  typedef logic [$clog2(`WORDS_PER_LINE)-1:0] lane_t;

  typedef logic [`PSEL_W-1:0] psel_t;      // Processor select

endpackage

// File: verilog/mem_bus_if.sv
`timescale 1ns/100ps
`include "mem_group_defs.svh"

// One lane per processor between the router and the memories
interface mem_bus_if;
  import mem_group_pkg::*;

  // Local port lanes
  logic [`NUM_PROC-1:0] we;       // Write enable after gating
  addr_t waddr [`NUM_PROC];
  addr_t raddr [`NUM_PROC];
  word_t wdata [`NUM_PROC];       // Halves or Ethernet word
  word_t rdata [`NUM_PROC];       // Registered read word

  // DDR lanes
  logic [`NUM_PROC-1:0] ddr_we;   // High only for the selected processor
  line_addr_t ddr_addr;           // Shared by all memories
  line_t ddr_din;                 // Shared write line
  line_t ddr_rdata [`NUM_PROC];   // Registered read line per processor

  modport router (
    output we, waddr, raddr, wdata,
    output ddr_we, ddr_addr, ddr_din,
    input  rdata, ddr_rdata
  );

  modport memory (
    input  we, waddr, raddr, wdata,
    input  ddr_we, ddr_addr, ddr_din,
    output rdata, ddr_rdata
  );

endinterface

// File: verilog/word_bank.sv
`timescale 1ns/100ps
`include "mem_group_defs.svh"

// 512 x 60 bank with a local port (A) and a DDR port (B)
module word_bank (
  input  logic                      clk1,
  input  logic                      rst,
  // Port A, local word access
  input  logic                      a_we,
  input  mem_group_pkg::line_addr_t a_waddr,
  input  mem_group_pkg::word_t      a_wdata,
  input  mem_group_pkg::line_addr_t a_raddr,
  output mem_group_pkg::word_t      a_rdata,
  // Port B, one slice of a DDR line
  input  logic                      b_we,
  input  mem_group_pkg::line_addr_t b_addr,
  input  mem_group_pkg::word_t      b_wdata,
  output mem_group_pkg::word_t      b_rdata
);
  import mem_group_pkg::*;

  localparam int DEPTH = 1 << `LINE_ADDR_W;  // 512 words

  word_t mem [DEPTH];

  ////////////////////////////////
  // Write side
  ////////////////////////////////
  // Port B is written last
  // so a DDR write beats a local write to the same word
  always_ff @(posedge clk1) begin
    if (a_we) begin
      mem[a_waddr] <= a_wdata;
    end
    if (b_we) begin
      mem[b_addr] <= b_wdata;  // Overrides A on collision
    end
  end

  ////////////////////////////////
  // Read side
  ////////////////////////////////
  // Read-first, old word comes out on a same-cycle write
  always_ff @(posedge clk1) begin
    if (rst) begin
      a_rdata <= '0;
      b_rdata <= '0;
    end else begin
      a_rdata <= mem[a_raddr];  // Local read
      b_rdata <= mem[b_addr];   // DDR read, shares the write address
    end
  end

endmodule

// File: verilog/processor_memory.sv
`timescale 1ns/100ps
`include "mem_group_defs.svh"

// One processor's 2048-word memory built from four word banks
// Word address = line * 4 + lane, lane picks the bank
module processor_memory #(
  parameter int PROC_ID = 0   // Lane of the bus used by this memory
) (
  input logic       clk1,
  input logic       rst,
  mem_bus_if.memory bus
);
  import mem_group_pkg::*;

  lane_t      w_lane;    // Bank hit by the local write
  line_addr_t w_line;
  lane_t      r_lane;    // Bank hit by the local read
  line_addr_t r_line;
  lane_t      r_lane_q;  // Read bank, aligned with bank output

  logic [`WORDS_PER_LINE-1:0] bank_we;  // Local write enable per bank

  word_t a_rdata [`WORDS_PER_LINE];  // Local read word of each bank
  word_t b_rdata [`WORDS_PER_LINE];  // DDR slice of each bank
  line_t ddr_line;

  ////////////////////////////////
  // Address split
  ////////////////////////////////
  assign {w_line, w_lane} = bus.waddr[PROC_ID];
  assign {r_line, r_lane} = bus.raddr[PROC_ID];

  // Bank index follows the data by one cycle
  always_ff @(posedge clk1) begin
    if (rst) begin
      r_lane_q <= '0;
    end else begin
      r_lane_q <= r_lane;
    end
  end

  ////////////////////////////////
  // Banks
  ////////////////////////////////
  for (genvar k = 0; k < `WORDS_PER_LINE; k++) begin : g_bank
    // Only the addressed bank takes a local write
    assign bank_we[k] = bus.we[PROC_ID] && (w_lane == lane_t'(k));

    word_bank u_bank (
      .clk1    (clk1),
      .rst     (rst),
      .a_we    (bank_we[k]),
      .a_waddr (w_line),
      .a_wdata (bus.wdata[PROC_ID]),
      .a_raddr (r_line),
      .a_rdata (a_rdata[k]),
      .b_we    (bus.ddr_we[PROC_ID]),                   // All banks on a DDR write
      .b_addr  (bus.ddr_addr),
      .b_wdata (bus.ddr_din[k*`WORD_W +: `WORD_W]),     // Word k of the line
      .b_rdata (b_rdata[k])
    );

    assign ddr_line[k*`WORD_W +: `WORD_W] = b_rdata[k];  // Word 0 lowest
  end

  ////////////////////////////////
  // Read return
  ////////////////////////////////
  assign bus.rdata[PROC_ID]     = a_rdata[r_lane_q];
  assign bus.ddr_rdata[PROC_ID] = ddr_line;

endmodule

// File: verilog/access_router.sv
`timescale 1ns/100ps
`include "mem_group_defs.svh"

// Gating, Ethernet data swap, DDR steering and output select
// Purely combinational
module access_router (
  input  mem_group_pkg::psel_t      processor_sel,
  input  logic                      sel_override,
  input  logic                      eth_all,
  input  logic                      eth_write,
  input  mem_group_pkg::word_t      eth_din,
  // Per-processor local ports
  input  logic [`NUM_PROC-1:0]      ram_we,
  input  mem_group_pkg::addr_t      write_addr [`NUM_PROC],
  input  mem_group_pkg::addr_t      read_addr [`NUM_PROC],
  input  mem_group_pkg::half_t      din_high [`NUM_PROC],
  input  mem_group_pkg::half_t      din_low [`NUM_PROC],
  // DDR port
  input  logic                      ddr_active,
  input  logic                      ddr_we,
  input  mem_group_pkg::line_addr_t ddr_addr,
  input  mem_group_pkg::line_t      ddr_din,
  // Read returns
  output mem_group_pkg::word_t      dout [`NUM_PROC],
  output mem_group_pkg::word_t      eth_dout,
  output mem_group_pkg::line_t      ddr_dout,
  mem_bus_if.router                 bus
);
  import mem_group_pkg::*;

  logic [`NUM_PROC-1:0] sel_hit;  // One-hot, all low when select out of range

  always_comb begin
    for (int p = 0; p < `NUM_PROC; p++) begin
      sel_hit[p] = (processor_sel == psel_t'(p));
    end
  end

  ////////////////////////////////
  // Write gating and data
  ////////////////////////////////
  always_comb begin
    for (int p = 0; p < `NUM_PROC; p++) begin
      if (eth_all) begin
        bus.we[p] = ram_we[p];               // Broadcast write, no gating
      end else if (sel_override) begin
        bus.we[p] = ram_we[p] && sel_hit[p]; // Selected processor only
      end else begin
        bus.we[p] = ram_we[p];
      end

      // Ethernet word replaces the halves on every lane
      if (eth_write) begin
        bus.wdata[p] = eth_din;
      end else begin
        bus.wdata[p] = {din_high[p], din_low[p]};
      end

      bus.waddr[p] = write_addr[p];
      bus.raddr[p] = read_addr[p];
    end
  end

  ////////////////////////////////
  // DDR steering
  ////////////////////////////////
  assign bus.ddr_we   = sel_hit & {`NUM_PROC{ddr_active && ddr_we}};
  assign bus.ddr_addr = ddr_addr;  // Shared by every memory
  assign bus.ddr_din  = ddr_din;

  ////////////////////////////////
  // Output select
  ////////////////////////////////
  // Selection happens after the read register, hold processor_sel
  always_comb begin
    eth_dout = '0;   // Zero when nothing is selected
    ddr_dout = '0;
    for (int p = 0; p < `NUM_PROC; p++) begin
      dout[p] = bus.rdata[p];
      if (sel_hit[p]) begin
        eth_dout = bus.rdata[p];
        ddr_dout = bus.ddr_rdata[p];
      end
    end
  end

endmodule

// File: verilog/memory_group.sv
`timescale 1ns/100ps
`include "mem_group_defs.svh"

// Group of processor-local memories with Ethernet and DDR access
module memory_group (
  input  logic                      clk1,
  input  logic                      rst,
  // Gating and Ethernet controls
  input  mem_group_pkg::psel_t      processor_sel,
  input  logic                      sel_override,
  input  logic                      eth_all,
  input  logic                      eth_write,
  input  mem_group_pkg::word_t      eth_din,
  // Per-processor local ports
  input  logic [`NUM_PROC-1:0]      ram_we,
  input  mem_group_pkg::addr_t      write_addr [`NUM_PROC],
  input  mem_group_pkg::addr_t      read_addr [`NUM_PROC],
  input  mem_group_pkg::half_t      din_high [`NUM_PROC],
  input  mem_group_pkg::half_t      din_low [`NUM_PROC],
  // DDR line port
  input  logic                      ddr_active,
  input  logic                      ddr_we,
  input  mem_group_pkg::line_addr_t ddr_addr,
  input  mem_group_pkg::line_t      ddr_din,
  // Read returns, one cycle after the address
  output mem_group_pkg::word_t      dout [`NUM_PROC],
  output mem_group_pkg::word_t      eth_dout,
  output mem_group_pkg::line_t      ddr_dout
);
  import mem_group_pkg::*;

  mem_bus_if bus ();  // Router to memory lanes

  ////////////////////////////////
  // Router
  ////////////////////////////////
  access_router u_router (
    .processor_sel (processor_sel),
    .sel_override  (sel_override),
    .eth_all       (eth_all),
    .eth_write     (eth_write),
    .eth_din       (eth_din),
    .ram_we        (ram_we),
    .write_addr    (write_addr),
    .read_addr     (read_addr),
    .din_high      (din_high),
    .din_low       (din_low),
    .ddr_active    (ddr_active),
    .ddr_we        (ddr_we),
    .ddr_addr      (ddr_addr),
    .ddr_din       (ddr_din),
    .dout          (dout),
    .eth_dout      (eth_dout),
    .ddr_dout      (ddr_dout),
    .bus           (bus)
  );

  ////////////////////////////////
  // Memories
  ////////////////////////////////
  for (genvar p = 0; p < `NUM_PROC; p++) begin : g_proc
    processor_memory #(
      .PROC_ID (p)   // Picks its own lane
    ) u_mem (
      .clk1 (clk1),
      .rst  (rst),
      .bus  (bus)
    );
  end

endmodule

// File: test/memory_group_tb.sv
`timescale 1ns/100ps
`include "mem_group_defs.svh"

module memory_group_tb;
  import mem_group_pkg::*;

  localparam int CLK_PERIOD       = 100;
  localparam int DEPTH            = 1 << `ADDR_W;  // Words per processor
  localparam int RESET_CYCLES     = 3;
  localparam int LOCAL_CYCLES     = 400;
  localparam int GATE_CYCLES      = 200;           // Per gating sub-phase
  localparam int ETH_CYCLES       = 200;
  localparam int DDR_ROUNDS       = 60;
  localparam int DDR_ROUND_CYCLES = 7;
  localparam int END_CYCLES       = 3;
  localparam int TOTAL_CYCLES = RESET_CYCLES + DEPTH + LOCAL_CYCLES + 2 * GATE_CYCLES
                              + ETH_CYCLES + DDR_ROUNDS * DDR_ROUND_CYCLES + END_CYCLES;

  logic                 clk1;
  logic                 rst;
  psel_t                processor_sel;
  logic                 sel_override;
  logic                 eth_all;
  logic                 eth_write;
  word_t                eth_din;
  logic [`NUM_PROC-1:0] ram_we;
  addr_t                write_addr [`NUM_PROC];
  addr_t                read_addr [`NUM_PROC];
  half_t                din_high [`NUM_PROC];
  half_t                din_low [`NUM_PROC];
  logic                 ddr_active;
  logic                 ddr_we;
  line_addr_t           ddr_addr;
  line_t                ddr_din;
  word_t                dout [`NUM_PROC];
  word_t                eth_dout;
  line_t                ddr_dout;

  word_t shadow [`NUM_PROC][DEPTH];   // Expected RAM contents
  bit    written [`NUM_PROC][DEPTH];  // Word holds known data
  word_t exp_rdata [`NUM_PROC];       // Expected read register per processor
  bit    exp_rvalid [`NUM_PROC];
  line_t exp_line [`NUM_PROC];        // Expected DDR read register
  bit    exp_lvalid [`NUM_PROC];
  addr_t last_waddr [`NUM_PROC];      // Write address of the previous cycle

  memory_group uut (
    .clk1          (clk1),
    .rst           (rst),
    .processor_sel (processor_sel),
    .sel_override  (sel_override),
    .eth_all       (eth_all),
    .eth_write     (eth_write),
    .eth_din       (eth_din),
    .ram_we        (ram_we),
    .write_addr    (write_addr),
    .read_addr     (read_addr),
    .din_high      (din_high),
    .din_low       (din_low),
    .ddr_active    (ddr_active),
    .ddr_we        (ddr_we),
    .ddr_addr      (ddr_addr),
    .ddr_din       (ddr_din),
    .dout          (dout),
    .eth_dout      (eth_dout),
    .ddr_dout      (ddr_dout)
  );

  initial begin : clock_gen
    clk1 = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk1 = ~clk1;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic word_t expected_word(int p, addr_t a);
    return shadow[p][a];
  endfunction

  // Word k of line l lives at local address l * 4 + k
  function automatic line_t expected_line(int p, line_addr_t l);
    line_t line;
    for (int k = 0; k < `WORDS_PER_LINE; k++) begin
      line[k*`WORD_W +: `WORD_W] = shadow[p][int'(l) * `WORDS_PER_LINE + k];
    end
    return line;
  endfunction

  function automatic bit line_written(int p, line_addr_t l);
    bit ok;
    ok = 1'b1;
    for (int k = 0; k < `WORDS_PER_LINE; k++) begin
      ok = ok && written[p][int'(l) * `WORDS_PER_LINE + k];
    end
    return ok;
  endfunction

  function automatic bit write_enabled(int p);
    if (eth_all) begin
      return ram_we[p];                                  // Broadcast ignores override
    end
    if (sel_override) begin
      return ram_we[p] && (int'(processor_sel) == p);
    end
    return ram_we[p];
  endfunction

  // Reads first with the old word on collision, then local writes and the DDR write
  always @(posedge clk1) begin : shadow_model
    for (int p = 0; p < `NUM_PROC; p++) begin
      if (rst) begin
        exp_rdata[p]  = '0;
        exp_rvalid[p] = 1'b1;
        exp_line[p]   = '0;
        exp_lvalid[p] = 1'b1;
      end else begin
        exp_rdata[p]  = expected_word(p, read_addr[p]);
        exp_rvalid[p] = written[p][read_addr[p]];
        exp_line[p]   = expected_line(p, ddr_addr);
        exp_lvalid[p] = line_written(p, ddr_addr);
      end
    end
    for (int p = 0; p < `NUM_PROC; p++) begin
      if (write_enabled(p)) begin
        shadow[p][write_addr[p]]  = eth_write ? eth_din : {din_high[p], din_low[p]};
        written[p][write_addr[p]] = 1'b1;
      end
    end
    if (ddr_active && ddr_we && int'(processor_sel) < `NUM_PROC) begin
      for (int k = 0; k < `WORDS_PER_LINE; k++) begin
        shadow[processor_sel][int'(ddr_addr) * `WORDS_PER_LINE + k] =
          ddr_din[k*`WORD_W +: `WORD_W];
        written[processor_sel][int'(ddr_addr) * `WORDS_PER_LINE + k] = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Checking
  //////////////////////////////
  task automatic check_value(string name, line_t got, line_t expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk1) begin : compare_outputs
    int sel;
    sel = int'(processor_sel);
    for (int p = 0; p < `NUM_PROC; p++) begin
      if (exp_rvalid[p]) check_value($sformatf("dout[%0d]", p), line_t'(dout[p]),
                                     line_t'(exp_rdata[p]));
    end
    if (sel >= `NUM_PROC) begin
      check_value("eth_dout", line_t'(eth_dout), '0);  // Nothing selected
      check_value("ddr_dout", ddr_dout, '0);
    end else begin
      if (exp_rvalid[sel]) check_value("eth_dout", line_t'(eth_dout), line_t'(exp_rdata[sel]));
      if (exp_lvalid[sel]) check_value("ddr_dout", ddr_dout, exp_line[sel]);
    end
  end

  initial begin : watchdog
    #((TOTAL_CYCLES + 100) * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", TOTAL_CYCLES + 100);
    $display("*** TEST FAILED ***");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  function automatic word_t random_word();
    return word_t'({$urandom, $urandom});
  endfunction

  function automatic line_t random_line();
    line_t line;
    for (int k = 0; k < `WORDS_PER_LINE; k++) begin
      line[k*`WORD_W +: `WORD_W] = random_word();
    end
    return line;
  endfunction

  task automatic quiet_inputs();
    ram_we       <= '0;
    sel_override <= 1'b0;
    eth_all      <= 1'b0;
    eth_write    <= 1'b0;
    ddr_active   <= 1'b0;
    ddr_we       <= 1'b0;
  endtask

  // Every processor writes addr a and reads the word written a cycle before
  task automatic fill_memories();
    for (int a = 0; a < DEPTH; a++) begin
      for (int p = 0; p < `NUM_PROC; p++) begin
        ram_we[p]     <= 1'b1;
        write_addr[p] <= addr_t'(a);
        read_addr[p]  <= addr_t'(a - 1);
        din_high[p]   <= half_t'($urandom);
        din_low[p]    <= half_t'($urandom);
      end
      @(posedge clk1);
    end
  endtask

  task automatic drive_local_cycle(bit all_we);
    addr_t wa;
    addr_t ra;
    for (int p = 0; p < `NUM_PROC; p++) begin
      wa = addr_t'($urandom);
      case ($urandom % 3)
        0:       ra = wa;              // Same word as this write
        1:       ra = last_waddr[p];   // Word written last cycle
        default: ra = addr_t'($urandom);
      endcase
      ram_we[p]     <= all_we | 1'($urandom);
      write_addr[p] <= wa;
      read_addr[p]  <= ra;
      din_high[p]   <= half_t'($urandom);
      din_low[p]    <= half_t'($urandom);
      last_waddr[p] = wa;
    end
    processor_sel <= psel_t'($urandom);  // 7 is out of range
    ddr_addr      <= line_addr_t'($urandom);
  endtask

  // Line write colliding with local writes, readback of its words and an inactive write
  task automatic ddr_round();
    psel_t      sel;
    line_addr_t line;
    sel  = psel_t'($urandom);
    line = line_addr_t'($urandom);
    quiet_inputs();
    processor_sel <= sel;
    ddr_active    <= 1'b1;
    ddr_we        <= 1'b1;
    ddr_addr      <= line;
    ddr_din       <= random_line();
    ram_we        <= '1;
    for (int p = 0; p < `NUM_PROC; p++) begin
      write_addr[p] <= {line, lane_t'($urandom)};  // Hits a word of the same line
      din_high[p]   <= half_t'($urandom);
      din_low[p]    <= half_t'($urandom);
    end
    @(posedge clk1);
    ram_we <= '0;
    ddr_we <= 1'b0;
    for (int k = 0; k < `WORDS_PER_LINE; k++) begin
      for (int p = 0; p < `NUM_PROC; p++) begin
        read_addr[p] <= {line, lane_t'(k)};
      end
      @(posedge clk1);
    end
    ddr_active <= 1'b0;  // Write request without the active flag
    ddr_we     <= 1'b1;
    ddr_din    <= random_line();
    @(posedge clk1);
    ddr_we <= 1'b0;
    @(posedge clk1);
  endtask

  initial begin : stimulus
    void'($urandom(32'h35605efd));
    rst           <= 1'b1;
    processor_sel <= '0;
    sel_override  <= 1'b0;
    eth_all       <= 1'b0;
    eth_write     <= 1'b0;
    eth_din       <= '0;
    ram_we        <= '1;    // RAM keeps taking writes during reset
    ddr_active    <= 1'b0;
    ddr_we        <= 1'b0;
    ddr_addr      <= '0;
    ddr_din       <= '0;
    // Nonzero word at address 0 sits in the read path while reset is high
    for (int p = 0; p < `NUM_PROC; p++) begin
      write_addr[p] <= '0;
      read_addr[p]  <= '0;
      din_high[p]   <= half_t'($urandom);
      din_low[p]    <= half_t'(p + 1);  // Never zero
      last_waddr[p] = '0;
    end

    repeat (RESET_CYCLES) @(posedge clk1);
    rst <= 1'b0;
    fill_memories();

    // Local ports with override low
    repeat (LOCAL_CYCLES) begin
      drive_local_cycle(1'b0);
      @(posedge clk1);
    end

    // Override gating and then broadcast through it
    sel_override <= 1'b1;
    repeat (GATE_CYCLES) begin
      drive_local_cycle(1'b1);
      @(posedge clk1);
    end
    eth_all <= 1'b1;
    repeat (GATE_CYCLES) begin
      drive_local_cycle(1'b1);
      @(posedge clk1);
    end

    // Ethernet data in place of the halves
    eth_write <= 1'b1;
    repeat (ETH_CYCLES) begin
      drive_local_cycle(1'b0);
      eth_din      <= random_word();
      sel_override <= 1'($urandom);
      eth_all      <= 1'($urandom);
      @(posedge clk1);
    end

    repeat (DDR_ROUNDS) ddr_round();

    quiet_inputs();
    repeat (END_CYCLES) @(posedge clk1);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: memory_group.f
+incdir+verilog
verilog/mem_group_pkg.sv
verilog/mem_bus_if.sv
verilog/word_bank.sv
verilog/processor_memory.sv
verilog/access_router.sv
verilog/memory_group.sv
test/memory_group_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the memory group testbench with Verilator and run it.
# Pass or fail is taken from the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  -f memory_group.f \
  --top-module memory_group_tb \
  -o memory_group_sim \
  && ./obj_dir/memory_group_sim | tee /dev/stderr \
  | grep -F "*** TEST PASSED ***" > /dev/null \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }
